// File: project.f
rtl/eth_stats_pkg.sv
rtl/eth_stats_adder.sv
rtl/bus_cdc.sv
rtl/rx_stats_domain.sv
rtl/stats_snapshot_fifo.sv
rtl/eth_stats_regs.sv
rtl/eth_stats_collector.sv
tests/eth_stats_properties.sv
tests/eth_stats_collector_tb.sv

// File: tests/eth_stats_collector_tb.sv
`default_nettype none

module eth_stats_collector_tb import eth_stats_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int max_cycles = 20000; // about four times the longest run.

	logic clk, clk_rx, reset;
	logic [count_w-1:0] current_time;
	logic time_running;
	logic [axi_addr_w-1:0] awaddr, araddr;
	logic [2:0] awprot, arprot;
	logic [axi_data_w-1:0] wdata, rdata;
	logic [3:0] wstrb;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic awready, wready, bvalid, arready, rvalid;
	logic [1:0] bresp, rresp;
	logic [rx_vec_w-1:0] rx_stats_vector;
	logic rx_stats_valid;
	logic [tx_vec_w-1:0] tx_stats_vector;
	logic tx_stats_valid;

	int seed = 33997;
	int errors = 0;
	int cycles = 0;
	// index 0 is time. the six totals follow in register order.
	string names [7] = '{"time", "tx_bytes", "tx_good", "tx_bad",
		"rx_bytes", "rx_good", "rx_bad"};
	logic [63:0] ref_v [7];  // expected totals.
	logic [63:0] snap_v [7]; // last popped snapshot.
	logic [63:0] prev_v [7];

	eth_stats_collector #(.use_time(1'b1), .use_fifo(1'b1), .fifo_depth(16)) dut0 (.*);

	always #5 clk = ~clk;
	always #7 clk_rx = ~clk_rx;
	always @(negedge clk) current_time <= current_time + 1'b1; // free running time.

	// ========================================
	// watchdog
	// ========================================
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run still going after %0d clk cycles", max_cycles);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] got);
		assert (got === exp) else begin
			errors++;
			$display("ERR %0t %s expected %h read %h", $time, name, exp, got);
		end
	endtask

	// ========================================
	// axi4-lite master
	// ========================================
	task automatic axi_write(input logic [axi_addr_w-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		while (!awready) @(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid) @(negedge clk);
		repeat ($unsigned($random(seed)) % 4) @(negedge clk); // response back-pressure.
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [axi_addr_w-1:0] addr, output logic [31:0] data);
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		arvalid = 1'b0;
		while (!rvalid) @(negedge clk);
		repeat ($unsigned($random(seed)) % 4) @(negedge clk);
		data = rdata; // held while rvalid.
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic read64(input logic [axi_addr_w-1:0] addr, output logic [63:0] value);
		logic [31:0] lo;
		logic [31:0] hi;
		axi_read(addr, lo);
		axi_read(addr + 12'h4, hi);
		value = {hi, lo};
	endtask

	// ========================================
	// frames and snapshots
	// ========================================
	task automatic send_tx(input bit counted);
		logic [frame_len_w-1:0] len;
		logic good;
		len = frame_len_w'(64 + ($unsigned($random(seed)) % 1455));
		good = ($unsigned($random(seed)) % 4) != 0; // mostly good frames.
		@(negedge clk);
		tx_stats_vector = '0;
		tx_stats_vector[len_lsb +: frame_len_w] = len;
		tx_stats_vector[good_bit] = good;
		tx_stats_valid = 1'b1;
		@(negedge clk);
		tx_stats_valid = 1'b0;
		if (counted) begin
			ref_v[1] += len;
			ref_v[good ? 2 : 3] += 1;
		end
	endtask

	task automatic send_rx(input int gap, input bit counted);
		logic [frame_len_w-1:0] len;
		logic good;
		len = frame_len_w'(64 + ($unsigned($random(seed)) % 1455));
		good = ($unsigned($random(seed)) % 4) != 0;
		repeat (gap) @(negedge clk_rx);
		rx_stats_vector = '0;
		rx_stats_vector[len_lsb +: frame_len_w] = len;
		rx_stats_vector[good_bit] = good;
		rx_stats_valid = 1'b1;
		@(negedge clk_rx);
		rx_stats_valid = 1'b0;
		if (counted) begin
			ref_v[4] += len;
			ref_v[good ? 5 : 6] += 1;
		end
	endtask

	task automatic wait_occupancy(input int expected);
		logic [31:0] occ;
		axi_read(reg_occup, occ);
		while (occ != expected) axi_read(reg_occup, occ);
	endtask

	// pops one entry and checks that no field goes backwards.
	task automatic pop_snapshot();
		axi_write(reg_pop, 32'h1);
		for (int i = 0; i < 7; i++) begin
			read64(12'(reg_time_l) + 12'(8 * i), snap_v[i]);
			assert (snap_v[i] >= prev_v[i]) else begin
				errors++;
				$display("ERR %0t %s decreased, previous %h read %h",
					$time, names[i], prev_v[i], snap_v[i]);
			end
			prev_v[i] = snap_v[i];
		end
	endtask

	task automatic check_totals();
		for (int i = 1; i < 7; i++) check_value(names[i], ref_v[i], snap_v[i]);
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial begin
		logic [31:0] v;
		logic [31:0] last_occ;
		clk = 1'b0;
		clk_rx = 1'b0;
		reset = 1'b1;
		current_time = '0;
		time_running = 1'b0;
		{awaddr, araddr, awprot, arprot, wdata, wstrb} = '0;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		rx_stats_vector = '0;
		rx_stats_valid = 1'b0;
		tx_stats_vector = '0;
		tx_stats_valid = 1'b0;
		for (int i = 0; i < 7; i++) begin
			ref_v[i] = '0;
			snap_v[i] = '0;
			prev_v[i] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// counting disabled by the enable bit and then by time_running.
		time_running = 1'b1;
		repeat (3) send_tx(1'b0);
		repeat (2) send_rx(2, 1'b0);
		@(negedge clk);
		time_running = 1'b0;
		axi_write(reg_cfg, 32'h1);
		repeat (3) send_tx(1'b0);
		repeat (2) send_rx(2, 1'b0);
		repeat (30) @(negedge clk);
		axi_read(reg_occup, v);
		check_value("occupancy", 0, v);
		pop_snapshot(); // fifo is empty so the snapshot stays zero.
		check_totals();

		// transmit counting.
		@(negedge clk);
		time_running = 1'b1;
		repeat (4) @(negedge clk);
		repeat (10) send_tx(1'b1);
		wait_occupancy(10);
		repeat (10) pop_snapshot();
		check_totals();

		// receive counting through the bus synchronizer.
		repeat (8) send_rx(20, 1'b1);
		repeat (20) @(negedge clk);
		last_occ = '1;
		axi_read(reg_occup, v);
		while (v != last_occ) begin // until transfers settle.
			last_occ = v;
			repeat (20) @(negedge clk);
			axi_read(reg_occup, v);
		end
		check_value("occupancy", 8, v);
		while (v != 0) begin
			pop_snapshot();
			axi_read(reg_occup, v);
		end
		check_totals();

		// pushes past 16 are dropped.
		repeat (20) send_tx(1'b1);
		repeat (10) @(negedge clk);
		axi_read(reg_occup, v);
		check_value("occupancy", 16, v);
		repeat (16) pop_snapshot();
		axi_read(reg_occup, v);
		check_value("occupancy", 0, v);

		// software clear and three fresh frames.
		axi_write(reg_cfg, 32'h3);
		axi_read(reg_cfg, v);
		check_value("reg_cfg", 3, v);
		repeat (10) @(negedge clk);
		axi_write(reg_cfg, 32'h1);
		for (int i = 1; i < 7; i++) begin
			ref_v[i] = '0;
			prev_v[i] = '0; // time keeps its order.
		end
		repeat (10) @(negedge clk);
		repeat (3) send_tx(1'b1);
		wait_occupancy(3);
		repeat (3) pop_snapshot();
		check_totals();

		// register map.
		axi_read(reg_rsvd, v);
		check_value("reg_rsvd", 0, v);
		axi_read(reg_pop, v);
		check_value("reg_pop", 0, v);
		axi_read(reg_cfg, v);
		check_value("reg_cfg", 1, v);
		axi_write(reg_cfg, 32'h0);
		axi_read(reg_cfg, v);
		check_value("reg_cfg", 0, v);

		repeat (5) @(negedge clk);
		$display("errors: %0d, assertion failures: %0d",
			errors, dut0.props0.fail_count);
		if (errors == 0 && dut0.props0.fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/eth_stats_properties.sv
`default_nettype none

// bus rules, fifo bound and counter order, seen from inside the top level.
module eth_stats_properties #(
	parameter int fifo_depth = 16
) (
	input logic clk,
	input logic reset,
	input logic awready,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic [1:0] bresp,
	input logic rvalid,
	input logic rready,
	input logic [1:0] rresp,
	input logic [31:0] rdata,
	input logic [15:0] occupancy,
	input logic [63:0] tx_bytes,
	input logic [63:0] tx_good,
	input logic [63:0] tx_bad,
	input logic count_clear
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0; // read by the testbench at the end.

	// ========================================
	// axi4-lite
	// ========================================
	bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else begin fail_count++; $error("bvalid dropped before bready"); end

	rvalid_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin fail_count++; $error("rvalid or rdata moved before rready"); end

	resp_okay: assert property (@(posedge clk) disable iff (reset)
		bresp == 2'b00 && rresp == 2'b00) // only okay is ever driven.
		else begin fail_count++; $error("response other than okay"); end

	aw_w_ready: assert property (@(posedge clk) disable iff (reset)
		awready == wready)
		else begin fail_count++; $error("awready and wready out of step"); end

	// ========================================
	// fifo and totals
	// ========================================
	occup_bound: assert property (@(posedge clk) disable iff (reset)
		occupancy <= 16'(fifo_depth))
		else begin fail_count++; $error("fifo occupancy above its depth"); end

	// a total may only fall on the cycle after a clear.
	tx_order: assert property (@(posedge clk) disable iff (reset)
		!$past(count_clear) |-> tx_bytes >= $past(tx_bytes)
			&& tx_good >= $past(tx_good) && tx_bad >= $past(tx_bad))
		else begin fail_count++; $error("transmit total decreased without clear"); end

endmodule

bind eth_stats_collector eth_stats_properties #(.fifo_depth(fifo_depth)) props0 (
	.clk, .reset, .awready, .wready, .bvalid, .bready, .bresp,
	.rvalid, .rready, .rresp, .rdata, .occupancy,
	.tx_bytes, .tx_good, .tx_bad, .count_clear
);

`default_nettype wire

// File: rtl/eth_stats_collector.sv
`default_nettype none

// ethernet statistics collector, top level.
module eth_stats_collector import eth_stats_pkg::*; #(
	parameter bit use_time = 1'b1,
	parameter bit use_fifo = 1'b1,
	parameter int fifo_depth = 16,
	parameter int sync_stages = 2
) (
	input logic clk,
	input logic clk_rx,
	input logic reset,

	input logic [count_w-1:0] current_time,
	input logic time_running,

	input logic [axi_addr_w-1:0] awaddr,
	input logic [2:0] awprot,
	input logic awvalid,
	output logic awready,
	input logic [axi_data_w-1:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [axi_addr_w-1:0] araddr,
	input logic [2:0] arprot,
	input logic arvalid,
	output logic arready,
	output logic [axi_data_w-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	input logic [rx_vec_w-1:0] rx_stats_vector,
	input logic rx_stats_valid,
	input logic [tx_vec_w-1:0] tx_stats_vector,
	input logic tx_stats_valid
);

	logic count_en, count_clear;
	logic [count_w-1:0] tx_bytes, tx_good, tx_bad;
	logic [count_w-1:0] rx_bytes, rx_good, rx_bad;         // clk side.
	logic [count_w-1:0] rx_bytes_r, rx_good_r, rx_bad_r;   // clk_rx side.
	logic tx_update, rx_update;
	logic push, pop, empty;
	logic [snap_w-1:0] push_data, head_data;
	logic [15:0] occupancy;

	eth_stats_regs #(.use_time(use_time), .use_fifo(use_fifo)) u_regs (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.current_time(current_time), .time_running(time_running),
		.tx_bytes(tx_bytes), .tx_good(tx_good), .tx_bad(tx_bad),
		.rx_bytes(rx_bytes), .rx_good(rx_good), .rx_bad(rx_bad),
		.tx_update(tx_update), .rx_update(rx_update),
		.head_data(head_data), .empty(empty), .occupancy(occupancy),
		.count_en(count_en), .count_clear(count_clear),
		.push(push), .push_data(push_data), .pop(pop)
	);

	// transmit side is already on clk.
	eth_stats_adder u_tx_adder (
		.clk(clk), .reset(reset), .clear(count_clear), .enable(count_en),
		.valid(tx_stats_valid),
		.frame_length(tx_stats_vector[len_lsb +: frame_len_w]),
		.frame_good(tx_stats_vector[good_bit]),
		.total_bytes(tx_bytes), .total_good(tx_good), .total_bad(tx_bad),
		.updated(tx_update)
	);

	rx_stats_domain #(.sync_stages(sync_stages)) u_rx (
		.clk_rx(clk_rx), .count_en(count_en), .count_clear(count_clear),
		.rx_stats_vector(rx_stats_vector), .rx_stats_valid(rx_stats_valid),
		.rx_bytes(rx_bytes_r), .rx_good(rx_good_r), .rx_bad(rx_bad_r)
	);

	// cleared with the counters, so both sides restart at zero.
	bus_cdc #(.width(3 * count_w), .sync_stages(sync_stages)) u_rx_cdc (
		.clk_src(clk_rx), .clk_dst(clk), .reset_dst(count_clear),
		.data_in({rx_bytes_r, rx_good_r, rx_bad_r}),
		.data_out({rx_bytes, rx_good, rx_bad}),
		.update(rx_update)
	);

	generate
		if (use_fifo) begin : g_fifo
			stats_snapshot_fifo #(.fifo_depth(fifo_depth)) u_fifo (
				.clk(clk), .reset(reset),
				.push(push), .push_data(push_data),
				.pop(pop), .head_data(head_data),
				.empty(empty), .occupancy(occupancy)
			);
		end else begin : g_no_fifo
			assign head_data = '0; // reads as an empty fifo.
			assign empty = 1'b1;
			assign occupancy = '0;
		end
	endgenerate

endmodule

`default_nettype wire

// File: rtl/eth_stats_regs.sv
`default_nettype none

// axi4-lite slave, config, gating, fifo control, read mux.
module eth_stats_regs import eth_stats_pkg::*; #(
	parameter bit use_time = 1'b1,
	parameter bit use_fifo = 1'b1
) (
	input logic clk,
	input logic reset,

	input logic [axi_addr_w-1:0] awaddr,
	input logic [2:0] awprot,
	input logic awvalid,
	output logic awready,
	input logic [axi_data_w-1:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [axi_addr_w-1:0] araddr,
	input logic [2:0] arprot,
	input logic arvalid,
	output logic arready,
	output logic [axi_data_w-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	input logic [count_w-1:0] current_time,
	input logic time_running,

	input logic [count_w-1:0] tx_bytes,
	input logic [count_w-1:0] tx_good,
	input logic [count_w-1:0] tx_bad,
	input logic [count_w-1:0] rx_bytes,
	input logic [count_w-1:0] rx_good,
	input logic [count_w-1:0] rx_bad,
	input logic tx_update,
	input logic rx_update,

	input logic [snap_w-1:0] head_data,
	input logic empty,
	input logic [15:0] occupancy,

	output logic count_en,
	output logic count_clear,
	output logic push,
	output logic [snap_w-1:0] push_data,
	output logic pop
);

	bus_state_e state;
	logic cfg_en;
	logic cfg_clear;
	logic [axi_addr_w-1:0] aw_word; // word aligned.
	logic [axi_addr_w-1:0] ar_addr_q;
	logic [count_w-1:0] last_time;  // time of last change.
	logic [snap_w-1:0] snap;        // popped entry.
	logic [snap_w-1:0] view;
	logic [count_w-1:0] v_time, v_txb, v_txg, v_txd, v_rxb, v_rxg, v_rxd;
	logic [axi_data_w-1:0] rd_word;

	assign aw_word = {awaddr[axi_addr_w-1:2], 2'b00};
	assign bresp = axi_okay;  // prot and strobes are not decoded.
	assign rresp = axi_okay;

	// ========================================
	// bus FSM and config register
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= bus_idle;
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			ar_addr_q <= '0;
			cfg_en <= 1'b0;
			cfg_clear <= 1'b0;
			pop <= 1'b0;
		end else begin
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			pop <= 1'b0;
			case (state)
				bus_idle: begin
					if (awvalid && wvalid) begin // write wins a tie.
						awready <= 1'b1;
						wready <= 1'b1;
						state <= bus_wresp;
						if (aw_word == reg_cfg) begin
							cfg_en <= wdata[0];
							cfg_clear <= wdata[1];
						end
						if (aw_word == reg_pop && wdata != '0 && !empty) begin
							pop <= 1'b1;
						end
					end else if (arvalid) begin
						arready <= 1'b1;
						ar_addr_q <= {araddr[axi_addr_w-1:2], 2'b00};
						state <= bus_rdata;
					end
				end
				bus_wresp: begin
					if (!bvalid) begin
						bvalid <= 1'b1; // cycle after the ready pulse.
					end else if (bready) begin
						bvalid <= 1'b0;
						state <= bus_idle;
					end
				end
				bus_rdata: begin
					if (!rvalid) begin
						rvalid <= 1'b1;
						rdata <= rd_word; // held until rready.
					end else if (rready) begin
						rvalid <= 1'b0;
						state <= bus_idle;
					end
				end
				default: state <= bus_idle;
			endcase
		end
	end

	// ========================================
	// gating, timestamp, snapshots
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			count_en <= 1'b0;
			count_clear <= 1'b1; // reset clears the totals too.
			last_time <= '0;
			push <= 1'b0;
			snap <= '0;
		end else begin
			count_en <= cfg_en & (time_running | ~use_time);
			count_clear <= cfg_clear;
			push <= use_fifo & (tx_update | rx_update);
			if (tx_update || rx_update) begin
				last_time <= use_time ? current_time : '0;
			end
			if (pop) begin
				snap <= head_data; // fifo advances on this edge.
			end
		end
	end

	// time is stamped already by the push cycle.
	assign push_data = {last_time, tx_bytes, tx_good, tx_bad, rx_bytes, rx_good, rx_bad};

	// live totals, or the popped entry in fifo mode.
	assign view = use_fifo ? snap : push_data;
	assign {v_time, v_txb, v_txg, v_txd, v_rxb, v_rxg, v_rxd} = view;

	always_comb begin
		rd_word = '0;
		case (reg_addr_e'(ar_addr_q))
			reg_cfg:        rd_word = {30'd0, cfg_clear, cfg_en};
			reg_occup:      rd_word = 32'(occupancy);
			reg_time_l:     rd_word = v_time[31:0];
			reg_time_h:     rd_word = v_time[63:32];
			reg_tx_bytes_l: rd_word = v_txb[31:0];
			reg_tx_bytes_h: rd_word = v_txb[63:32];
			reg_tx_good_l:  rd_word = v_txg[31:0];
			reg_tx_good_h:  rd_word = v_txg[63:32];
			reg_tx_bad_l:   rd_word = v_txd[31:0];
			reg_tx_bad_h:   rd_word = v_txd[63:32];
			reg_rx_bytes_l: rd_word = v_rxb[31:0];
			reg_rx_bytes_h: rd_word = v_rxb[63:32];
			reg_rx_good_l:  rd_word = v_rxg[31:0];
			reg_rx_good_h:  rd_word = v_rxg[63:32];
			reg_rx_bad_l:   rd_word = v_rxd[31:0];
			reg_rx_bad_h:   rd_word = v_rxd[63:32];
			default:        rd_word = '0; // pop, rsvd, unmapped.
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/stats_snapshot_fifo.sv
`default_nettype none

// circular buffer of timestamped snapshots.
module stats_snapshot_fifo import eth_stats_pkg::*; #(
	parameter int fifo_depth = 16
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic [snap_w-1:0] push_data,
	input logic pop,
	output logic [snap_w-1:0] head_data,
	output logic empty,
	output logic [15:0] occupancy
);

	localparam int ptr_w = $clog2(fifo_depth);

	logic [snap_w-1:0] mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count; // one extra bit for full.
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == (ptr_w + 1)'(fifo_depth));
	assign empty = (count == '0);
	assign do_push = push & ~full;  // dropped when full.
	assign do_pop = pop & ~empty;
	assign head_data = mem[rd_ptr];
	assign occupancy = 16'(count);

	// storage, no reset.
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps.
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither.
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/rx_stats_domain.sv
`default_nettype none

// receive counting on clk_rx.
module rx_stats_domain import eth_stats_pkg::*; #(
	parameter int sync_stages = 2
) (
	input logic clk_rx,
	input logic count_en,     // clk domain.
	input logic count_clear,  // clk domain. carries reset too.
	input logic [rx_vec_w-1:0] rx_stats_vector,
	input logic rx_stats_valid,
	output logic [count_w-1:0] rx_bytes,
	output logic [count_w-1:0] rx_good,
	output logic [count_w-1:0] rx_bad
);

	logic [sync_stages-1:0] en_sync;
	logic [sync_stages-1:0] clr_sync;

	// plain flop chains into clk_rx.
	always_ff @(posedge clk_rx) begin
		en_sync <= {en_sync[sync_stages-2:0], count_en};
		clr_sync <= {clr_sync[sync_stages-2:0], count_clear};
	end

	eth_stats_adder u_rx_adder (
		.clk(clk_rx),
		.reset(clr_sync[sync_stages-1]),
		.clear(clr_sync[sync_stages-1]),
		.enable(en_sync[sync_stages-1]),
		.valid(rx_stats_valid),
		.frame_length(rx_stats_vector[len_lsb +: frame_len_w]),
		.frame_good(rx_stats_vector[good_bit]),
		.total_bytes(rx_bytes),
		.total_good(rx_good),
		.total_bad(rx_bad),
		.updated() // bus_cdc finds the change itself.
	);

endmodule

`default_nettype wire

// File: rtl/bus_cdc.sv
`default_nettype none

// toggle handshake for a wide bus, src to dst.
module bus_cdc #(
	parameter int width = 192,
	parameter int sync_stages = 2
) (
	input logic clk_src,
	input logic clk_dst,
	input logic reset_dst,
	input logic [width-1:0] data_in,
	output logic [width-1:0] data_out,
	output logic update
);

	// ========================================
	// source side
	// ========================================
	logic [sync_stages-1:0] rst_sync;  // reset_dst seen in clk_src.
	logic reset_src;
	logic [width-1:0] hold;            // stable while a transfer is open.
	logic req_tgl;
	logic ack_tgl;
	logic [sync_stages-1:0] ack_sync;

	always_ff @(posedge clk_src) begin
		rst_sync <= {rst_sync[sync_stages-2:0], reset_dst};
	end

	assign reset_src = rst_sync[sync_stages-1];

	always_ff @(posedge clk_src) begin
		if (reset_src) begin
			hold <= '0;
			req_tgl <= 1'b0;
			ack_sync <= '0;
		end else begin
			ack_sync <= {ack_sync[sync_stages-2:0], ack_tgl};
			// idle when the ack has caught up. only changes are sent.
			if (req_tgl == ack_sync[sync_stages-1] && data_in != hold) begin
				hold <= data_in;
				req_tgl <= ~req_tgl;
			end
		end
	end

	// ========================================
	// destination side
	// ========================================
	logic [sync_stages-1:0] req_sync;

	always_ff @(posedge clk_dst) begin
		if (reset_dst) begin
			req_sync <= '0;
			ack_tgl <= 1'b0;
			data_out <= '0;
			update <= 1'b0;
		end else begin
			req_sync <= {req_sync[sync_stages-2:0], req_tgl};
			update <= 1'b0;
			if (req_sync[sync_stages-1] != ack_tgl) begin // new value waiting.
				data_out <= hold;
				update <= 1'b1;
				ack_tgl <= req_sync[sync_stages-1]; // hands hold back to src.
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/eth_stats_adder.sv
`default_nettype none

// byte, good and bad frame totals from one status stream.
module eth_stats_adder import eth_stats_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic clear,
	input logic enable,

	input logic valid,
	input logic [frame_len_w-1:0] frame_length,
	input logic frame_good,

	output logic [count_w-1:0] total_bytes,
	output logic [count_w-1:0] total_good,
	output logic [count_w-1:0] total_bad,
	output logic updated
);

	logic take; // report accepted this cycle.

	assign take = valid & enable;

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			total_bytes <= '0;
			total_good <= '0;
			total_bad <= '0;
			updated <= 1'b0;
		end else begin
			updated <= take; // one cycle, with the new totals.
			if (take) begin
				total_bytes <= total_bytes + count_w'(frame_length);
				// exactly one of the frame counters moves.
				if (frame_good) begin
					total_good <= total_good + 1'b1;
				end else begin
					total_bad <= total_bad + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/eth_stats_pkg.sv
`default_nettype none

package eth_stats_pkg;

	// ========================================
	// widths and vector fields
	// ========================================
	localparam int count_w = 64;        // every total and the timestamp.
	localparam int frame_len_w = 14;    // frame length field.
	localparam int tx_vec_w = 32;
	localparam int rx_vec_w = 28;
	localparam int len_lsb = 5;         // length field position, both vectors.
	localparam int good_bit = 0;        // good-frame flag, both vectors.
	localparam int snap_w = 7 * count_w; // time, then six totals.

	localparam int axi_addr_w = 12;
	localparam int axi_data_w = 32;

	// ========================================
	// register map, byte addresses
	// ========================================
	typedef enum logic [axi_addr_w-1:0] {
		reg_cfg        = 12'h000, // bit 0 enable, bit 1 clear.
		reg_occup      = 12'h004,
		reg_pop        = 12'h008, // write nonzero to pop.
		reg_rsvd       = 12'h00C,
		reg_time_l     = 12'h010,
		reg_time_h     = 12'h014,
		reg_tx_bytes_l = 12'h018,
		reg_tx_bytes_h = 12'h01C,
		reg_tx_good_l  = 12'h020,
		reg_tx_good_h  = 12'h024,
		reg_tx_bad_l   = 12'h028,
		reg_tx_bad_h   = 12'h02C,
		reg_rx_bytes_l = 12'h030,
		reg_rx_bytes_h = 12'h034,
		reg_rx_good_l  = 12'h038,
		reg_rx_good_h  = 12'h03C,
		reg_rx_bad_l   = 12'h040,
		reg_rx_bad_h   = 12'h044
	} reg_addr_e;

	typedef enum logic [1:0] {
		axi_okay   = 2'b00,
		axi_slverr = 2'b10
	} axi_resp_e;

	// slave states.
	typedef enum logic [1:0] {
		bus_idle,
		bus_wresp,
		bus_rdata
	} bus_state_e;

endpackage

`default_nettype wire
